// ==== sim.f ====
+incdir+common
common/riscvPkg.sv
hw/insnDecoder.sv
hw/alu.sv
core/byteLanes.sv
core/coreSequencer.sv
hw/riscvCore.sv
test/tbMemory.sv
test/tbRiscvCore.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module tbRiscvCore \
    -Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simv | tee sim.log
if [ "${PIPESTATUS[0]}" -ne 0 ]; then
    echo "Simulation exited with an error"
    exit 1
fi

if grep -q "ALL TESTS PASSED" sim.log; then
    exit 0
fi
echo "Pass line not found in sim.log"
exit 1

// ==== test/tbRiscvCore.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "riscv_params.svh"

module tbRiscvCore;
    import riscvPkg::*;

    localparam int BaseWord = `RESET_PC / 4;
    // Store takes about 25 cycles with the slowest memory
    localparam int MaxCyclesPerInsn = 40;

    logic cpuSignals;
    logic rst;
    MemReq memReq;
    MemRsp memRsp;
    logic [31:0] lfsrState;
    logic [31:0] refMem [0:(1 << `ADDR_WIDTH)-1];
    logic [31:0] progWords[$];
    int testOf[$];
    int testErrors;
    int failedTests;
    int handshakeErrors;
    string testNames[7];

    riscvCore dut0 (.cpuSignals(cpuSignals), .rst(rst), .memRsp(memRsp), .memReq(memReq));
    tbMemory mem0 (.cpuSignals(cpuSignals), .rst(rst), .memReq(memReq), .memRsp(memRsp));

    initial begin
        cpuSignals = 1'b0;
        forever #10 cpuSignals = ~cpuSignals;
    end

    // Request held steady until ready
    assert property (@(posedge cpuSignals) disable iff (rst)
        (memReq.strobe && !memRsp.ready) |=> (memReq.strobe && $stable(memReq.address)
        && $stable(memReq.writeEnable) && $stable(memReq.dataWrite)))
    else begin
        handshakeErrors++;
        $display("Request changed or dropped before ready at %0t", $time);
    end

    // No fetch may overlap the write that ends an instruction
    assert property (@(posedge cpuSignals) disable iff (rst)
        (memRsp.ready && memReq.writeEnable) |=> !memReq.strobe)
    else begin
        handshakeErrors++;
        $display("Strobe stayed high right after a write ack at %0t", $time);
    end

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] nextLfsr(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] randomWord();
        logic [31:0] w;
        for (int b = 0; b < 32; b++) begin
            lfsrState = nextLfsr(lfsrState);
            w[b] = lfsrState[0];
        end
        return w;
    endfunction

    function automatic logic [31:0] encI(input logic [6:0] opc, input logic [2:0] f3,
                                         input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
    endfunction

    function automatic logic [31:0] encS(input logic [2:0] f3, input int rs1, input int rs2,
                                         input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3, imm[4:0], 7'h23};
    endfunction

    function automatic void addInsn(input logic [31:0] w, input int test);
        progWords.push_back(w);
        testOf.push_back(test);
    endfunction

    // Reference ISA model on refMem
    function automatic void execute(input logic [31:0] w);
        logic [31:0] x;
        logic [31:0] immI;
        logic [31:0] immS;
        logic [31:0] addr;
        logic [31:0] word;
        logic [31:0] src;
        logic [3:0] rd;
        logic [2:0] f3;
        rd = w[10:7];
        f3 = w[14:12];
        x = refMem[w[18:15]];
        src = refMem[w[23:20]];
        immI = {{20{w[31]}}, w[31:20]};
        immS = {{20{w[31]}}, w[31:25], w[11:7]};
        case (w[6:0])
            7'h37: refMem[rd] = {w[31:12], 12'h000};
            7'h13: begin
                case (f3)
                    3'd0: refMem[rd] = x + immI;
                    3'd1: refMem[rd] = x << immI[4:0];
                    3'd2: refMem[rd] = {31'd0, $signed(x) < $signed(immI)};
                    3'd3: refMem[rd] = {31'd0, x < immI};
                    3'd4: refMem[rd] = x ^ immI;
                    3'd5: refMem[rd] = w[30] ? $unsigned($signed(x) >>> immI[4:0])
                                                : x >> immI[4:0];
                    3'd6: refMem[rd] = x | immI;
                    default: refMem[rd] = x & immI;
                endcase
            end
            7'h03: begin
                addr = x + immI;
                word = refMem[addr[16:2]] >> (8 * addr[1:0]);
                case (f3)
                    3'd0: refMem[rd] = {{24{word[7]}}, word[7:0]};
                    3'd4: refMem[rd] = {24'd0, word[7:0]};
                    3'd1: refMem[rd] = {{16{word[15]}}, word[15:0]};
                    3'd5: refMem[rd] = {16'd0, word[15:0]};
                    default: refMem[rd] = word;
                endcase
            end
            7'h23: begin
                addr = x + immS;
                word = refMem[addr[16:2]];
                if (f3 == 3'd0) begin
                    word[8 * addr[1:0] +: 8] = src[7:0];
                end else if (f3 == 3'd1) begin
                    word[16 * addr[1] +: 16] = src[15:0];
                end else begin
                    word = src;
                end
                refMem[addr[16:2]] = word;
            end
            // Anything else leaves the state alone
            default: ;
        endcase
    endfunction

    // Registers and the data block against the model
    task automatic compareState();
        int a;
        for (int i = 0; i < 32; i++) begin
            a = i < 16 ? i : 'h100 + i - 16;
            assert (mem0.words[a] === refMem[a])
            else begin
                testErrors++;
                $display("[ERROR] mem0.words[%h] = %h, expected %h", a, mem0.words[a], refMem[a]);
            end
        end
    endtask

    task automatic waitFetch(input int word);
        do @(posedge cpuSignals);
        while (!(memReq.strobe && !memReq.writeEnable && memReq.address == word));
    endtask

    task automatic reportTest(input int t);
        $display("test %0d %s: %s (%0d errors)", t, testNames[t],
                 testErrors == 0 ? "ok" : "failed", testErrors);
        if (testErrors != 0) begin
            failedTests++;
        end
        testErrors = 0;
    endtask

    initial begin
        #1;
        #((progWords.size() * MaxCyclesPerInsn + 20) * 20 * 2);
        $display("Timeout, the core stopped fetching instructions");
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        rst = 1'b1;
        lfsrState = 32'h939e_21d4;
        testErrors = 0;
        failedTests = 0;
        handshakeErrors = 0;
        testNames = '{"", "reset", "handshake", "alu", "loads", "stores", "unsupported"};
        // LUI and ALU immediate
        addInsn({20'h12345, 5'd1, 7'h37}, 3);
        addInsn({20'hfffff, 5'd2, 7'h37}, 3);
        addInsn(encI(7'h13, 3'd0, 3, 4, -5), 3);
        addInsn(encI(7'h13, 3'd0, 5, 3, 100), 3);
        // Signed and unsigned compares disagree on these operands
        addInsn(encI(7'h13, 3'd2, 6, 1, -1), 3);
        addInsn(encI(7'h13, 3'd2, 7, 2, 2000), 3);
        addInsn(encI(7'h13, 3'd3, 8, 2, 5), 3);
        addInsn(encI(7'h13, 3'd3, 9, 1, -1), 3);
        addInsn(encI(7'h13, 3'd4, 10, 4, -1), 3);
        addInsn(encI(7'h13, 3'd6, 11, 4, 'h0f0), 3);
        addInsn(encI(7'h13, 3'd7, 12, 4, 'h7ff), 3);
        addInsn(encI(7'h13, 3'd1, 13, 4, 7), 3);
        addInsn(encI(7'h13, 3'd5, 14, 2, 4), 3);
        addInsn(encI(7'h13, 3'd5, 15, 2, 'h404), 3);
        addInsn(encI(7'h13, 3'd5, 3, 4, 'h41f), 3);
        addInsn(encI(7'h13, 3'd5, 5, 4, 31), 3);
        // x1 points at data word 0x100
        addInsn({20'h00000, 5'd1, 7'h37}, 4);
        addInsn(encI(7'h13, 3'd0, 1, 1, 'h400), 4);
        for (int k = 0; k < 4; k++) begin
            addInsn(encI(7'h03, 3'd0, 2 + k, 1, 4 + k), 4);
            addInsn(encI(7'h03, 3'd4, 6 + k, 1, 4 + k), 4);
        end
        addInsn(encI(7'h03, 3'd1, 10, 1, 4), 4);
        addInsn(encI(7'h03, 3'd1, 11, 1, 6), 4);
        addInsn(encI(7'h03, 3'd5, 12, 1, 4), 4);
        addInsn(encI(7'h03, 3'd5, 13, 1, 6), 4);
        addInsn(encI(7'h03, 3'd2, 14, 1, 0), 4);
        addInsn(encI(7'h03, 3'd0, 15, 1, -1), 4);
        for (int k = 0; k < 4; k++) begin
            addInsn(encS(3'd0, 1, 3 + k, 8 + k), 5);
        end
        addInsn(encS(3'd1, 1, 7, 12), 5);
        addInsn(encS(3'd1, 1, 8, 14), 5);
        addInsn(encS(3'd2, 1, 9, 16), 5);
        // R-type add and a non-32-bit word, then a normal ADDI
        addInsn(32'h0020_81b3, 6);
        addInsn(32'h0000_0000, 6);
        addInsn(encI(7'h13, 3'd0, 10, 10, 1), 6);
        @(posedge cpuSignals);
        for (int i = 0; i < progWords.size(); i++) begin
            mem0.words[BaseWord + i] = progWords[i];
        end
        for (int i = 0; i < 16; i++) begin
            mem0.words[i] = randomWord();
            mem0.words['h101 - 1 + i] = randomWord();
        end
        // Byte and half-word sign bits both set and clear
        mem0.words['h101] = 32'h807f_01fe;
        for (int i = 0; i < (1 << `ADDR_WIDTH); i++) begin
            refMem[i] = mem0.words[i];
        end
        @(posedge cpuSignals);
        @(posedge cpuSignals);
        rst <= 1'b0;
        @(posedge cpuSignals);
        assert (memReq.strobe === 1'b0 && memReq.writeEnable === 1'b0)
        else begin
            testErrors++;
            $display("[ERROR] memReq.strobe = %h, memReq.writeEnable = %h, expected 0 0",
                     memReq.strobe, memReq.writeEnable);
        end
        @(posedge cpuSignals);
        assert (memReq.strobe === 1'b1 && memReq.address === BaseWord && !memReq.writeEnable)
        else begin
            testErrors++;
            $display("[ERROR] memReq.strobe = %h, memReq.writeEnable = %h, memReq.address = %h",
                     memReq.strobe, memReq.writeEnable, memReq.address);
            $display("[ERROR] expected memReq.strobe = 1, memReq.writeEnable = 0, address %h",
                     BaseWord);
        end
        reportTest(1);
        for (int i = 0; i < progWords.size(); i++) begin
            waitFetch(BaseWord + i + 1);
            execute(progWords[i]);
            compareState();
            if (i == progWords.size() - 1 || testOf[i + 1] != testOf[i]) begin
                reportTest(testOf[i]);
            end
        end
        testErrors = handshakeErrors;
        reportTest(2);
        $display("tests run 6, failed %0d, handshake errors %0d", failedTests, handshakeErrors);
        if (failedTests == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/tbMemory.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "riscv_params.svh"

module tbMemory (
    input  logic            cpuSignals,
    input  logic            rst,
    input  riscvPkg::MemReq memReq,
    output riscvPkg::MemRsp memRsp
);
    import riscvPkg::*;

    // 32 Ki words, registers in the low sixteen
    logic [`XLEN-1:0] words [0:(1 << `ADDR_WIDTH)-1];
    logic [31:0] lfsrState;
    logic busy;
    logic [1:0] waitLeft;

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] nextLfsr(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    initial begin
        lfsrState = 32'h939e_21d4;
        busy = 1'b0;
        waitLeft = 2'd0;
        memRsp = '0;
        // Fill depends on every address bit
        for (int i = 0; i < (1 << `ADDR_WIDTH); i++) begin
            words[i] = {i[15:0] ^ 16'h5a3c, ~i[15:0]};
        end
    end

    always @(posedge cpuSignals) begin
        logic [1:0] delay;
        memRsp.ready <= 1'b0;
        if (rst) begin
            busy <= 1'b0;
        end else if (memReq.strobe && !memRsp.ready) begin
            if (busy) begin
                delay = waitLeft;
            end else begin
                // Two LFSR bits give 0 to 2 extra cycles
                lfsrState = nextLfsr(lfsrState);
                delay[1] = lfsrState[0];
                lfsrState = nextLfsr(lfsrState);
                delay[0] = lfsrState[0];
                if (delay == 2'd3) begin
                    delay = 2'd0;
                end
            end
            if (delay == 2'd0) begin
                busy <= 1'b0;
                memRsp.ready <= 1'b1;
                if (memReq.writeEnable) begin
                    words[memReq.address] <= memReq.dataWrite;
                end else begin
                    memRsp.dataRead <= words[memReq.address];
                end
            end else begin
                busy <= 1'b1;
                waitLeft <= delay - 2'd1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/riscvCore.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "riscv_params.svh"

module riscvCore (
    input  logic            cpuSignals,
    input  logic            rst,
    input  riscvPkg::MemRsp memRsp,
    output riscvPkg::MemReq memReq
);
    import riscvPkg::*;

    logic [`XLEN-1:0] insnWord;
    DecodedInsn decoded;
    AluOp aluOp;
    logic [`XLEN-1:0] aluX;
    logic [`XLEN-1:0] aluY;
    logic [`XLEN-1:0] aluResult;
    logic [1:0] addrLow;
    logic [`XLEN-1:0] rawWord;
    logic [`XLEN-1:0] oldWord;
    logic [`XLEN-1:0] loadValue;
    logic [`XLEN-1:0] storeWord;

    // Sequencer owns all state, the rest is combinational
    coreSequencer seq0 (
        .cpuSignals(cpuSignals), .rst(rst), .memRsp(memRsp), .memReq(memReq),
        .insnWord(insnWord), .decoded(decoded), .aluOp(aluOp), .aluX(aluX),
        .aluY(aluY), .aluResult(aluResult), .addrLow(addrLow), .rawWord(rawWord),
        .oldWord(oldWord), .loadValue(loadValue), .storeWord(storeWord)
    );

    insnDecoder dec0 (.insnWord(insnWord), .decoded(decoded));

    alu alu0 (.op(aluOp), .x(aluX), .y(aluY), .result(aluResult));

    byteLanes lanes0 (
        .decoded(decoded), .addrLow(addrLow), .rawWord(rawWord), .oldWord(oldWord),
        .loadValue(loadValue), .storeWord(storeWord)
    );

endmodule

`default_nettype wire

// ==== core/coreSequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "riscv_params.svh"

module coreSequencer (
    input  logic                 cpuSignals,
    input  logic                 rst,
    input  riscvPkg::MemRsp      memRsp,
    output riscvPkg::MemReq      memReq,
    output logic [`XLEN-1:0]     insnWord,
    input  riscvPkg::DecodedInsn decoded,
    output riscvPkg::AluOp       aluOp,
    output logic [`XLEN-1:0]     aluX,
    output logic [`XLEN-1:0]     aluY,
    input  logic [`XLEN-1:0]     aluResult,
    output logic [1:0]           addrLow,
    output logic [`XLEN-1:0]     rawWord,
    output logic [`XLEN-1:0]     oldWord,
    input  logic [`XLEN-1:0]     loadValue,
    input  logic [`XLEN-1:0]     storeWord
);
    import riscvPkg::*;

    SeqState state;
    // PC counts 32-bit words
    logic [`ADDR_WIDTH-1:0] pc;
    // Word address of the current load or store
    logic [`ADDR_WIDTH-1:0] dataAddr;
    // Set while regFetch reads rs2 of a store
    logic fetchRs2;
    logic [`ADDR_WIDTH-1:0] writeAddr;
    logic [`XLEN-1:0] writeValue;

    // Registers sit in the lowest memory words
    function automatic logic [`ADDR_WIDTH-1:0] regAddr(input logic [`REG_IDX_WIDTH-1:0] idx);
        return `ADDR_WIDTH'(idx);
    endfunction

    // Target and value of the final write of an instruction
    always_comb begin
        if (decoded.isStore) begin
            writeAddr = dataAddr;
        end else begin
            writeAddr = regAddr(decoded.rdIdx);
        end
        if (decoded.isLui) begin
            writeValue = decoded.immediate;
        end else if (decoded.isLoad) begin
            writeValue = loadValue;
        end else if (decoded.isStore) begin
            writeValue = storeWord;
        end else begin
            writeValue = aluResult;
        end
    end

    always_ff @(posedge cpuSignals) begin
        if (rst) begin
            state <= insnFetch;
            pc <= `ADDR_WIDTH'(`RESET_PC / 4);
            memReq.strobe <= 1'b0;
            memReq.writeEnable <= 1'b0;
            fetchRs2 <= 1'b0;
        end else begin
            case (state)
                insnFetch: begin
                    if (!memReq.strobe) begin
                        // Start the read of the next instruction word
                        memReq.address <= pc;
                        memReq.writeEnable <= 1'b0;
                        memReq.strobe <= 1'b1;
                    end else if (memRsp.ready) begin
                        insnWord <= memRsp.dataRead;
                        memReq.strobe <= 1'b0;
                        state <= insnDecode;
                    end
                end

                insnDecode: begin
                    if (decoded.isLoad || decoded.isStore || decoded.isAluOp) begin
                        // Every remaining kind starts with rs1
                        memReq.address <= regAddr(decoded.rs1Idx);
                        memReq.strobe <= 1'b1;
                        state <= regFetch;
                    end else if (decoded.isLui) begin
                        state <= regStore;
                    end else begin
                        // Unknown opcode, nothing to do
                        state <= insnDone;
                    end
                end

                regFetch: begin
                    if (memRsp.ready) begin
                        memReq.strobe <= 1'b0;
                        if (fetchRs2) begin
                            // rs2 goes to the lane unit for the merge
                            rawWord <= memRsp.dataRead;
                            fetchRs2 <= 1'b0;
                            state <= regStore;
                        end else begin
                            aluX <= memRsp.dataRead;
                            aluY <= decoded.immediate;
                            // Loads and stores add the offset to rs1
                            aluOp <= decoded.isAluOp ? decoded.aluOp : opAdd;
                            state <= aluStep;
                        end
                    end
                end

                aluStep: begin
                    if (decoded.isAluOp) begin
                        state <= regStore;
                    end else begin
                        dataAddr <= aluResult[`ADDR_WIDTH+1:2];
                        addrLow <= aluResult[1:0];
                        memReq.address <= aluResult[`ADDR_WIDTH+1:2];
                        memReq.strobe <= 1'b1;
                        state <= dataFetch;
                    end
                end

                dataFetch: begin
                    if (memRsp.ready) begin
                        if (decoded.isStore) begin
                            // Keep the old word, read rs2 right away
                            oldWord <= memRsp.dataRead;
                            memReq.address <= regAddr(decoded.rs2Idx);
                            fetchRs2 <= 1'b1;
                            state <= regFetch;
                        end else begin
                            rawWord <= memRsp.dataRead;
                            memReq.strobe <= 1'b0;
                            state <= regStore;
                        end
                    end
                end

                regStore: begin
                    if (!memReq.strobe) begin
                        // Sources are all registered, so the request stays stable
                        memReq.address <= writeAddr;
                        memReq.dataWrite <= writeValue;
                        memReq.writeEnable <= 1'b1;
                        memReq.strobe <= 1'b1;
                    end else if (memRsp.ready) begin
                        memReq.strobe <= 1'b0;
                        memReq.writeEnable <= 1'b0;
                        state <= insnDone;
                    end
                end

                insnDone: begin
                    pc <= pc + 1'b1;
                    state <= insnFetch;
                end

                default: begin
                    state <= insnFetch;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== core/byteLanes.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "riscv_params.svh"

module byteLanes (
    input  riscvPkg::DecodedInsn decoded,
    input  logic [1:0]           addrLow,
    input  logic [`XLEN-1:0]     rawWord,
    input  logic [`XLEN-1:0]     oldWord,
    output logic [`XLEN-1:0]     loadValue,
    output logic [`XLEN-1:0]     storeWord
);
    import riscvPkg::*;

    logic [7:0] laneByte;
    logic [15:0] laneHalf;
    logic byteSign;
    logic halfSign;

    // Addressed lanes of the read word
    assign laneByte = rawWord[{addrLow, 3'b000} +: 8];
    assign laneHalf = addrLow[1] ? rawWord[31:16] : rawWord[15:0];

    // Zero when the load is unsigned
    assign byteSign = decoded.isLoadSigned & laneByte[7];
    assign halfSign = decoded.isLoadSigned & laneHalf[15];

    always_comb begin
        case (decoded.size)
            byteSize: loadValue = {{24{byteSign}}, laneByte};
            halfSize: loadValue = {{16{halfSign}}, laneHalf};
            default: loadValue = rawWord;
        endcase
    end

    // rawWord holds rs2 here, its low part lands in the addressed lane
    always_comb begin
        storeWord = oldWord;
        case (decoded.size)
            byteSize: storeWord[{addrLow, 3'b000} +: 8] = rawWord[7:0];
            halfSize: storeWord[{addrLow[1], 4'b0000} +: 16] = rawWord[15:0];
            default: storeWord = rawWord;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/alu.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "riscv_params.svh"

module alu (
    input  riscvPkg::AluOp    op,
    input  logic [`XLEN-1:0] x,
    input  logic [`XLEN-1:0] y,
    output logic [`XLEN-1:0] result
);
    import riscvPkg::*;

    logic [4:0] shamt;

    // Shift amount is the low five bits of y
    assign shamt = y[4:0];

    always_comb begin
        case (op)
            opAdd: result = x + y;
            opSub: result = x - y;
            opAnd: result = x & y;
            opOr: result = x | y;
            opXor: result = x ^ y;
            opSll: result = x << shamt;
            opSrl: result = x >> shamt;
            // Arithmetic shift keeps the sign
            opSra: result = $unsigned($signed(x) >>> shamt);
            opSlt: result = $signed(x) < $signed(y) ? `XLEN'(1) : '0;
            // Remaining code is SLTU
            default: result = x < y ? `XLEN'(1) : '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/insnDecoder.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "riscv_params.svh"

module insnDecoder (
    input  logic [`XLEN-1:0]      insnWord,
    output riscvPkg::DecodedInsn decoded
);
    import riscvPkg::*;

    // Major opcode groups in bits 6:2
    typedef enum logic [4:0] {
        majLoad  = 5'b00000,
        majOpImm = 5'b00100,
        majStore = 5'b01000,
        majLui   = 5'b01101
    } MajorOpcode;

    MajorOpcode major;
    logic [2:0] funct3;
    logic       is32;

    assign major = MajorOpcode'(insnWord[6:2]);
    assign funct3 = insnWord[14:12];
    // Only full-size encodings count, anything else falls through as a no-op
    assign is32 = insnWord[1:0] == 2'b11;

    assign decoded.isLoad = is32 && major == majLoad;
    assign decoded.isStore = is32 && major == majStore;
    assign decoded.isLui = is32 && major == majLui;
    assign decoded.isAluOp = is32 && major == majOpImm;
    // funct3 bit 2 marks the unsigned loads
    assign decoded.isLoadSigned = !funct3[2];

    assign decoded.rs1Idx = insnWord[15 +: `REG_IDX_WIDTH];
    assign decoded.rs2Idx = insnWord[20 +: `REG_IDX_WIDTH];
    assign decoded.rdIdx = insnWord[7 +: `REG_IDX_WIDTH];

    // Bit 30 only selects SRAI over SRLI, elsewhere it is immediate data
    assign decoded.aluOp = AluOp'({funct3 == 3'b101 && insnWord[30], funct3});

    always_comb begin
        case (funct3[1:0])
            2'b00: decoded.size = byteSize;
            2'b01: decoded.size = halfSize;
            default: decoded.size = wordSize;
        endcase
    end

    // Immediate format follows the major opcode
    always_comb begin
        case (major)
            majLoad, majOpImm:
                decoded.immediate = {{20{insnWord[31]}}, insnWord[31:20]};
            majStore:
                decoded.immediate = {{20{insnWord[31]}}, insnWord[31:25], insnWord[11:7]};
            majLui:
                decoded.immediate = {insnWord[31:12], 12'b0};
            default:
                decoded.immediate = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== common/riscvPkg.sv ====
`default_nettype none

`include "riscv_params.svh"

package riscvPkg;

    // Bit 30 of the instruction followed by funct3
    typedef enum logic [3:0] {
        opAdd  = 4'b0000,
        opSub  = 4'b1000,
        opSll  = 4'b0001,
        opSlt  = 4'b0010,
        opSltu = 4'b0011,
        opXor  = 4'b0100,
        opSrl  = 4'b0101,
        opSra  = 4'b1101,
        opOr   = 4'b0110,
        opAnd  = 4'b0111
    } AluOp;

    // Multicycle sequencer steps
    typedef enum logic [2:0] {
        insnFetch,
        insnDecode,
        regFetch,
        aluStep,
        dataFetch,
        regStore,
        insnDone
    } SeqState;

    // Request side of the strobe/ready memory bus
    typedef struct packed {
        logic [`ADDR_WIDTH-1:0] address;
        logic [`XLEN-1:0]       dataWrite;
        // High for a write, dataWrite valid with it
        logic                   writeEnable;
        logic                   strobe;
    } MemReq;

    // Response side, ready lasts one cycle
    typedef struct packed {
        logic [`XLEN-1:0] dataRead;
        logic             ready;
    } MemRsp;

    typedef enum logic [1:0] {
        byteSize,
        halfSize,
        wordSize
    } TransferSize;

    // Decoder output consumed by the sequencer and the lane unit
    typedef struct packed {
        logic                      isLoad;
        logic                      isStore;
        logic                      isLui;
        logic                      isAluOp;
        logic                      isLoadSigned;
        TransferSize               size;
        logic [`REG_IDX_WIDTH-1:0] rs1Idx;
        logic [`REG_IDX_WIDTH-1:0] rs2Idx;
        logic [`REG_IDX_WIDTH-1:0] rdIdx;
        logic [`XLEN-1:0]          immediate;
        AluOp                      aluOp;
    } DecodedInsn;

endpackage

`default_nettype wire

// ==== common/riscv_params.svh ====
`ifndef RISCV_PARAMS_SVH
`define RISCV_PARAMS_SVH

// Address bits for 32-bit memory words
`define ADDR_WIDTH 15

// Data path width
`define XLEN 32

// Register index width, sixteen registers kept in memory
`define REG_IDX_WIDTH 4

// Byte address of the first instruction
`define RESET_PC 'h1000

`endif
